// ==== rf_subsys_top.f ====
hw/rf_pkg.sv
hw/rf_reset_sync.sv
hw/rf_array_2p.sv
hw/rf_pwr_gate_ctl.sv
hw/rf_pg_16x12.sv
hw/rf_subsys_top.sv
verification/rf_subsys_asserts.sv
verification/rf_subsys_tb.sv

// ==== verification/rf_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_subsys_tb;

    import rf_pkg::*;

    localparam int SYNC_STAGES   = 2;
    localparam int PWR_ACK_DELAY = 3;
    localparam int ACK_TIMEOUT   = 64;

    // Operation codes used in the stimulus table
    localparam int OP_WRITE    = 0;
    localparam int OP_READ     = 1;
    localparam int OP_READ_ALL = 2;
    localparam int OP_PWR_OFF  = 3;
    localparam int OP_PWR_ON   = 4;
    localparam int OP_ISO_ON   = 5;
    localparam int OP_ISO_OFF  = 6;
    localparam int OP_SCAN_ON  = 7;
    localparam int OP_SCAN_OFF = 8;

    logic                clk;
    logic                rst;
    rf_wr_t              wr_req [2];
    rf_rd_t              rd_req [2];
    logic [RF_WIDTH-1:0] rdata [2];
    rf_pwr_t             pwr;
    logic                pwr_enable_b_out;
    logic                fscan_rstbypen;
    logic                fscan_byprst_b;

    // Reference model of both banks, plus the last unclamped read result
    logic [RF_WIDTH-1:0] model_mem [2][RF_DEPTH];
    logic                model_valid [2][RF_DEPTH];
    logic [RF_WIDTH-1:0] last_rd [2];
    bit                  powered;
    bit                  scan_held;
    int                  errors;

    // Stimulus table columns, one entry per row
    int                  tbl_op [$];
    int                  tbl_bank [$];
    int                  tbl_addr [$];
    int                  tbl_data [$];
    string               tbl_name [$];

    rf_subsys_top #(
        .SYNC_STAGES    (SYNC_STAGES)
       ,.PWR_ACK_DELAY  (PWR_ACK_DELAY)
    ) u_rf_subsys_top (
         .wclk              (clk)
        ,.rclk              (clk)
        ,.rst               (rst)
        ,.wr0               (wr_req[0])
        ,.wr1               (wr_req[1])
        ,.rd0               (rd_req[0])
        ,.rd1               (rd_req[1])
        ,.rdata0            (rdata[0])
        ,.rdata1            (rdata[1])
        ,.pwr               (pwr)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
        ,.fscan_rstbypen    (fscan_rstbypen)
        ,.fscan_byprst_b    (fscan_byprst_b)
    );

    // Both the write and the read clock come from this one source
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_row(input int op, input int bank, input int addr, input int data,
                           input string name);
        tbl_op.push_back(op);
        tbl_bank.push_back(bank);
        tbl_addr.push_back(addr);
        tbl_data.push_back(data);
        tbl_name.push_back(name);
    endtask

    // Power loss and reset both drop every entry and the read register
    task automatic drop_contents();
        for (int b = 0; b < 2; b++) begin
            last_rd[b] = '0;
            for (int a = 0; a < RF_DEPTH; a++) begin
                model_valid[b][a] = 1'b0;
            end
        end
    endtask

    // Counts rclk cycles until the chain acknowledge reaches the given level
    task automatic wait_ack(input logic level, output int cycles);
        bit done;
        cycles = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            if (pwr_enable_b_out === level) begin
                done = 1'b1;
            end else if (cycles >= ACK_TIMEOUT) begin
                $display("Power chain acknowledge did not reach %0b within %0d cycles",
                         level, cycles);
                $display("sim failed");
                $fatal(1, "acknowledge timeout");
            end
        end
    endtask

    task automatic do_write(input int bank, input int addr, input int data);
        rf_wr_t w;
        w.en   = 1'b1;
        w.addr = addr[RF_AWIDTH-1:0];
        w.data = data[RF_WIDTH-1:0];
        @(posedge clk);
        wr_req[bank] <= w;
        @(posedge clk);
        wr_req[bank] <= '0;
        // A write only lands in a powered bank that is out of reset
        if (powered && !scan_held) begin
            model_mem[bank][addr]   = data[RF_WIDTH-1:0];
            model_valid[bank][addr] = 1'b1;
        end
    endtask

    // Issues one read per cycle and checks each result one cycle later
    task automatic read_burst(input int bank, input int first, input int count,
                              input string name);
        rf_rd_t r;
        logic [RF_WIDTH-1:0] expected;
        for (int i = 0; i <= count; i++) begin
            r.en   = (i < count);
            r.addr = 4'(first + i);
            @(posedge clk);
            rd_req[bank] <= (i < count) ? r : '0;
            if (i > 0) begin
                @(negedge clk);
                expected = model_valid[bank][first+i-1] ? model_mem[bank][first+i-1] : '0;
                last_rd[bank] = expected;
                check_value($sformatf("%s[%0d]", name, first + i - 1),
                            pwr.isol_en ? '0 : expected, rdata[bank]);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------

    // A data value of -1 asks for a random word
    task automatic build_table();
        add_row(OP_READ_ALL, 0, 0, 0, "reset_b0");
        add_row(OP_READ_ALL, 1, 0, 0, "reset_b1");
        add_row(OP_WRITE, 0, 3, 'h5a1, "wr_b0_3");
        add_row(OP_WRITE, 0, 4, -1, "wr_b0_4");
        add_row(OP_WRITE, 1, 3, 'h0f0, "wr_b1_3");
        add_row(OP_WRITE, 1, 9, -1, "wr_b1_9");
        add_row(OP_READ_ALL, 0, 0, 0, "b2b_b0");
        add_row(OP_READ_ALL, 1, 0, 0, "b2b_b1");
        add_row(OP_READ, 0, 3, 0, "rd_b0_3");
        add_row(OP_READ, 1, 3, 0, "rd_b1_3");
        add_row(OP_ISO_ON, 0, 0, 0, "iso_on");
        add_row(OP_READ, 0, 4, 0, "rd_isolated");
        add_row(OP_ISO_OFF, 0, 0, 0, "iso_off");
        add_row(OP_PWR_OFF, 0, 0, 0, "pwr_off_ack");
        add_row(OP_WRITE, 0, 5, 'h123, "wr_off_b0");
        add_row(OP_WRITE, 1, 6, 'h456, "wr_off_b1");
        add_row(OP_PWR_ON, 0, 0, 0, "pwr_on_ack");
        add_row(OP_READ_ALL, 0, 0, 0, "after_pwr_b0");
        add_row(OP_READ_ALL, 1, 0, 0, "after_pwr_b1");
        add_row(OP_WRITE, 0, 7, -1, "wr_b0_7");
        add_row(OP_READ, 0, 7, 0, "rd_b0_7");
        add_row(OP_SCAN_ON, 0, 0, 0, "scan_on");
        add_row(OP_WRITE, 0, 8, 'h777, "wr_scan");
        add_row(OP_READ, 0, 7, 0, "rd_scan_7");
        add_row(OP_READ, 0, 8, 0, "rd_scan_8");
        add_row(OP_SCAN_OFF, 0, 0, 0, "scan_off_ack");
        add_row(OP_READ_ALL, 0, 0, 0, "after_scan_b0");
        add_row(OP_READ_ALL, 1, 0, 0, "after_scan_b1");
    endtask

    initial begin
        int cycles;
        int data;
        void'($urandom(98684));
        rst            = 1'b1;
        wr_req[0]      = '0;
        wr_req[1]      = '0;
        rd_req[0]      = '0;
        rd_req[1]      = '0;
        pwr            = '0;
        fscan_rstbypen = 1'b0;
        fscan_byprst_b = 1'b1;
        errors         = 0;
        powered        = 1'b1;
        scan_held      = 1'b0;
        drop_contents();
        build_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // Both banks come up once the chain acknowledge has fallen
        wait_ack(1'b0, cycles);
        for (int i = 0; i < tbl_op.size(); i++) begin
            case (tbl_op[i])
                OP_WRITE: begin
                    data = (tbl_data[i] < 0) ? int'($urandom() & 'hfff) : tbl_data[i];
                    do_write(tbl_bank[i], tbl_addr[i], data);
                end
                OP_READ:     read_burst(tbl_bank[i], tbl_addr[i], 1, tbl_name[i]);
                OP_READ_ALL: read_burst(tbl_bank[i], 0, RF_DEPTH, tbl_name[i]);
                OP_PWR_OFF, OP_PWR_ON: begin
                    @(posedge clk);
                    pwr.enable_b <= (tbl_op[i] == OP_PWR_OFF);
                    wait_ack(tbl_op[i] == OP_PWR_OFF, cycles);
                    check_value(tbl_name[i], 2 * PWR_ACK_DELAY, cycles);
                    powered = (tbl_op[i] == OP_PWR_ON);
                    drop_contents();
                end
                OP_ISO_ON, OP_ISO_OFF: begin
                    @(posedge clk);
                    pwr.isol_en <= (tbl_op[i] == OP_ISO_ON);
                    @(negedge clk);
                    for (int b = 0; b < 2; b++) begin
                        check_value(tbl_name[i], (tbl_op[i] == OP_ISO_ON) ? '0 : last_rd[b],
                                    rdata[b]);
                    end
                end
                OP_SCAN_ON: begin
                    @(posedge clk);
                    fscan_rstbypen <= 1'b1;
                    fscan_byprst_b <= 1'b0;
                    scan_held = 1'b1;
                    drop_contents();
                end
                OP_SCAN_OFF: begin
                    @(posedge clk);
                    fscan_rstbypen <= 1'b0;
                    fscan_byprst_b <= 1'b1;
                    // Leaving reset ramps the whole chain again from the off state
                    wait_ack(1'b0, cycles);
                    check_value(tbl_name[i], 2 * PWR_ACK_DELAY, cycles);
                    scan_held = 1'b0;
                end
                default: check_value("unknown_op", 0, tbl_op[i]);
            endcase
        end
        if (errors == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

// ==== verification/rf_subsys_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_subsys_asserts (
     input  logic                        rclk
    ,input  logic                        rst_sync
    ,input  logic                        pgcb_isol_en
    ,input  logic                        pwr_off
    ,input  logic                        pwr_enable_b_out
    ,input  logic [rf_pkg::RF_WIDTH-1:0] rdata
);

    // ------------------------------------------------------------
    // Power and isolation rules of one bank
    // ------------------------------------------------------------

    // Isolation clamps the bank output combinationally
    isol_clamps_rdata: assert property (@(posedge rclk) pgcb_isol_en |-> rdata == '0)
        else $error("read data not zero while isolated");

    // A powered-off bank clears its read register on the next edge
    pwr_off_clears_rdata: assert property (@(posedge rclk) pwr_off |=> rdata == '0)
        else $error("read data not cleared after power off");

    // Reset puts the whole switch chain into the off state
    rst_holds_ack_off: assert property (@(posedge rclk) rst_sync |=> pwr_enable_b_out)
        else $error("power acknowledge low during reset");

endmodule

bind rf_pg_16x12 rf_subsys_asserts u_asserts (
     .rclk              (rclk)
    ,.rst_sync          (rst_sync)
    ,.pgcb_isol_en      (pgcb_isol_en)
    ,.pwr_off           (pwr_off)
    ,.pwr_enable_b_out  (pwr_enable_b_out)
    ,.rdata             (rdata)
);

`default_nettype wire

// ==== hw/rf_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_subsys_top #(
    parameter int SYNC_STAGES   = 2
   ,parameter int PWR_ACK_DELAY = 3
) (
     input  logic                        wclk
    ,input  logic                        rclk
    ,input  logic                        rst

    // Per-bank write and read requests
    ,input  rf_pkg::rf_wr_t              wr0
    ,input  rf_pkg::rf_wr_t              wr1
    ,input  rf_pkg::rf_rd_t              rd0
    ,input  rf_pkg::rf_rd_t              rd1
    ,output logic [rf_pkg::RF_WIDTH-1:0] rdata0
    ,output logic [rf_pkg::RF_WIDTH-1:0] rdata1

    // Power chain
    ,input  rf_pkg::rf_pwr_t             pwr
    ,output logic                        pwr_enable_b_out

    // Scan reset bypass
    ,input  logic                        fscan_rstbypen
    ,input  logic                        fscan_byprst_b
);

    // Acknowledge of bank 0, which powers up bank 1
    logic bank0_pwr_enable_b_out;

    // ------------------------------------------------------------
    // Bank 0 sits at the head of the power chain
    // ------------------------------------------------------------

    rf_pg_16x12 #(
        .SYNC_STAGES    (SYNC_STAGES)
       ,.PWR_ACK_DELAY  (PWR_ACK_DELAY)
    ) u_bank0 (
         .wclk              (wclk)
        ,.rclk              (rclk)
        ,.rst               (rst)
        ,.wr                (wr0)
        ,.rd                (rd0)
        ,.rdata             (rdata0)
        ,.pgcb_isol_en      (pwr.isol_en)
        ,.pwr_enable_b_in   (pwr.enable_b)
        ,.pwr_enable_b_out  (bank0_pwr_enable_b_out)
        ,.fscan_rstbypen    (fscan_rstbypen)
        ,.fscan_byprst_b    (fscan_byprst_b)
    );

    // Bank 1 closes the chain and returns the final acknowledge
    rf_pg_16x12 #(
        .SYNC_STAGES    (SYNC_STAGES)
       ,.PWR_ACK_DELAY  (PWR_ACK_DELAY)
    ) u_bank1 (
         .wclk              (wclk)
        ,.rclk              (rclk)
        ,.rst               (rst)
        ,.wr                (wr1)
        ,.rd                (rd1)
        ,.rdata             (rdata1)
        ,.pgcb_isol_en      (pwr.isol_en)
        ,.pwr_enable_b_in   (bank0_pwr_enable_b_out)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
        ,.fscan_rstbypen    (fscan_rstbypen)
        ,.fscan_byprst_b    (fscan_byprst_b)
    );

endmodule

`default_nettype wire

// ==== hw/rf_pg_16x12.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_pg_16x12 #(
    parameter int SYNC_STAGES   = 2
   ,parameter int PWR_ACK_DELAY = 3
) (
     input  logic                        wclk
    ,input  logic                        rclk
    ,input  logic                        rst

    // Functional ports
    ,input  rf_pkg::rf_wr_t              wr
    ,input  rf_pkg::rf_rd_t              rd
    ,output logic [rf_pkg::RF_WIDTH-1:0] rdata

    // Power interface
    ,input  logic                        pgcb_isol_en
    ,input  logic                        pwr_enable_b_in
    ,output logic                        pwr_enable_b_out

    // Scan reset bypass
    ,input  logic                        fscan_rstbypen
    ,input  logic                        fscan_byprst_b
);

    import rf_pkg::*;

    // Reset in the read clock domain, shared by the controller and the array
    logic                rst_sync;

    // High while the bank is unpowered or still ramping
    logic                pwr_off;

    // Array read data before output isolation
    logic [RF_WIDTH-1:0] array_rdata;

    // ------------------------------------------------------------
    // Reset synchronizer
    // ------------------------------------------------------------

    rf_reset_sync #(
        .SYNC_STAGES    (SYNC_STAGES)
    ) u_reset_sync (
         .rclk            (rclk)
        ,.rst             (rst)
        ,.fscan_rstbypen  (fscan_rstbypen)
        ,.fscan_byprst_b  (fscan_byprst_b)
        ,.rst_sync        (rst_sync)
    );

    // ------------------------------------------------------------
    // Power gate controller
    // ------------------------------------------------------------

    // The acknowledge leaves the bank on the daisy chain toward the next bank
    rf_pwr_gate_ctl #(
        .PWR_ACK_DELAY  (PWR_ACK_DELAY)
    ) u_pwr_gate_ctl (
         .rclk             (rclk)
        ,.rst_sync         (rst_sync)
        ,.pwr_enable_b_in  (pwr_enable_b_in)
        ,.pwr_enable_b_out (pwr_enable_b_out)
        ,.pwr_off          (pwr_off)
    );

    // ------------------------------------------------------------
    // Storage array
    // ------------------------------------------------------------

    rf_array_2p u_array (
         .wclk      (wclk)
        ,.rclk      (rclk)
        ,.rst_sync  (rst_sync)
        ,.pwr_off   (pwr_off)
        ,.wr        (wr)
        ,.rd        (rd)
        ,.rdata     (array_rdata)
    );

    // Output isolation clamps the read data to zero without touching
    // the read register, so the last result returns once isolation drops
    assign rdata = pgcb_isol_en ? '0 : array_rdata;

endmodule

`default_nettype wire

// ==== hw/rf_pwr_gate_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_pwr_gate_ctl #(
    parameter int PWR_ACK_DELAY = 3
) (
     input  logic rclk
    ,input  logic rst_sync
    ,input  logic pwr_enable_b_in
    ,output logic pwr_enable_b_out
    ,output logic pwr_off
);

    // ------------------------------------------------------------
    // Power switch chain model
    // ------------------------------------------------------------

    // Each flop stands for one segment of the power switch daisy chain
    // inside the macro, so the enable ripples through one segment per cycle
    logic [PWR_ACK_DELAY-1:0] dly_q;

    // During reset the whole chain is treated as switched off
    // After reset the chain follows the incoming enable one stage per cycle
    always_ff @(posedge rclk) begin
        if (rst_sync) begin
            dly_q <= '1;
        end else begin
            dly_q[0] <= pwr_enable_b_in;
            for (int i = 1; i < PWR_ACK_DELAY; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    // The last segment is the acknowledge handed to the next bank
    assign pwr_enable_b_out = dly_q[PWR_ACK_DELAY-1];

    // ------------------------------------------------------------
    // Power lost indication
    // ------------------------------------------------------------

    // The bank is unusable from the moment the request to switch off arrives
    // until the chain has fully ramped back up
    // A high input end means power is being removed
    // A high output end means the switches have not all closed yet
    assign pwr_off = pwr_enable_b_in | pwr_enable_b_out;

    // While pwr_off is high the array drops its valid bits every cycle,
    // so anything stored before the power cycle is gone once the bank
    // comes back, and writes seen in the meantime are refused

endmodule

`default_nettype wire

// ==== hw/rf_array_2p.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_array_2p (
     input  logic                        wclk
    ,input  logic                        rclk
    ,input  logic                        rst_sync
    ,input  logic                        pwr_off
    ,input  rf_pkg::rf_wr_t              wr
    ,input  rf_pkg::rf_rd_t              rd
    ,output logic [rf_pkg::RF_WIDTH-1:0] rdata
);

    import rf_pkg::*;

    // Storage words and their per-entry valid flags
    logic [RF_WIDTH-1:0] mem_q [RF_DEPTH];
    logic [RF_DEPTH-1:0] valid_q;

    // Registered read port
    logic [RF_WIDTH-1:0] rdata_q;
    logic [RF_WIDTH-1:0] rd_word;

    // A write only lands when the bank is powered and out of reset
    logic                wr_ok;

    assign wr_ok = wr.en && !rst_sync && !pwr_off;

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------

    // Losing power or entering reset drops every entry at once
    always_ff @(posedge wclk) begin
        if (rst_sync || pwr_off) begin
            valid_q <= '0;
        end else if (wr_ok) begin
            valid_q[wr.addr] <= 1'b1;
        end
    end

    always_ff @(posedge wclk) begin
        if (wr_ok) begin
            mem_q[wr.addr] <= wr.data;
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------

    // An entry that was never written, or was lost with power, reads as zero
    assign rd_word = valid_q[rd.addr] ? mem_q[rd.addr] : '0;

    // The result appears one cycle after rd.en and holds until the next read
    always_ff @(posedge rclk) begin
        if (rst_sync || pwr_off) begin
            rdata_q <= '0;
        end else if (rd.en) begin
            rdata_q <= rd_word;
        end
    end

    assign rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hw/rf_reset_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module rf_reset_sync #(
    parameter int SYNC_STAGES = 2
) (
     input  logic rclk
    ,input  logic rst
    ,input  logic fscan_rstbypen
    ,input  logic fscan_byprst_b
    ,output logic rst_sync
);

    // Shift chain that carries the subsystem reset into the read clock domain
    logic [SYNC_STAGES-1:0] sync_q;

    // The first stage samples the raw reset and each later stage follows the one before
    always_ff @(posedge rclk) begin
        sync_q[0] <= rst;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
        end
    end

    // ------------------------------------------------------------
    // Scan reset bypass
    // ------------------------------------------------------------

    // In scan mode the test controller owns the reset directly
    // fscan_byprst_b is active low, so it is inverted to match rst_sync
    assign rst_sync = fscan_rstbypen ? ~fscan_byprst_b : sync_q[SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== hw/rf_pkg.sv ====
`default_nettype none

package rf_pkg;

    // ------------------------------------------------------------
    // Array geometry
    // ------------------------------------------------------------

    // Number of entries in one register file bank
    localparam int RF_DEPTH  = 16;

    // Width of one stored word in bits
    localparam int RF_WIDTH  = 12;

    // Address width follows from the entry count
    localparam int RF_AWIDTH = $clog2(RF_DEPTH);

    // ------------------------------------------------------------
    // Request and power types
    // ------------------------------------------------------------

    // Write request, a plain strobe sampled on the write clock
    typedef struct packed {
        logic                 en;
        logic [RF_AWIDTH-1:0] addr;
        logic [RF_WIDTH-1:0]  data;
    } rf_wr_t;

    // Read request, sampled on the read clock
    typedef struct packed {
        logic                 en;
        logic [RF_AWIDTH-1:0] addr;
    } rf_rd_t;

    // Power controls shared by the bank chain
    // enable_b high means the supply of the first bank is switched off
    typedef struct packed {
        logic isol_en;
        logic enable_b;
    } rf_pwr_t;

endpackage

`default_nettype wire
